/* mcu.sv */
`default_nettype none

module mcu import mcu_pkg::*; (
    input  wire logic        clk_i,
    input  wire logic        arst_n_i,
    // Core instruction port
    input  wire obi_req_t    instr_req_i,
    output obi_rsp_t         instr_rsp_o,
    // Core data port
    input  wire obi_req_t    data_req_i,
    output obi_rsp_t         data_rsp_o,
    // Pins
    input  wire logic        rx_i,
    output logic             tx_o,
    input  wire logic [15:0] in_i,
    output logic      [15:0] out_o,
    // Timer interrupt, line 7 on the core side
    output logic             irq_o,
    input  wire logic        irq_ack_i,
    input  wire logic [4:0]  irq_id_i
);

    mcu_bus u_bus (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .instr_req_i (instr_req_i),
        .instr_rsp_o (instr_rsp_o),
        .data_req_i  (data_req_i),
        .data_rsp_o  (data_rsp_o),
        .rx_i        (rx_i),
        .tx_o        (tx_o),
        .in_i        (in_i),
        .out_o       (out_o),
        .irq_o       (irq_o),
        .irq_ack_i   (irq_ack_i),
        .irq_id_i    (irq_id_i)
    );

endmodule

`default_nettype wire

/* mcu_bus.sv */
`default_nettype none

module mcu_bus import mcu_pkg::*; (
    input  wire logic        clk_i,
    input  wire logic        arst_n_i,
    input  wire obi_req_t    instr_req_i,
    output obi_rsp_t         instr_rsp_o,
    input  wire obi_req_t    data_req_i,
    output obi_rsp_t         data_rsp_o,
    input  wire logic        rx_i,
    output logic             tx_o,
    input  wire logic [15:0] in_i,
    output logic      [15:0] out_o,
    output logic             irq_o,
    input  wire logic        irq_ack_i,
    input  wire logic [4:0]  irq_id_i
);

    logic sel_ram;
    logic sel_uart;
    logic sel_gpio;
    logic sel_timer;
    logic instr_in_ram;

    obi_req_t ram_instr_req;
    obi_req_t ram_data_req;
    reg_req_t uart_req;
    reg_req_t gpio_req;
    reg_req_t timer_req;

    logic [31:0] ram_instr_rdata;
    logic [31:0] ram_data_rdata;
    logic [31:0] uart_rdata;
    logic [31:0] gpio_rdata;
    logic [31:0] timer_rdata;
    logic [31:0] periph_rdata;

    // Response state, one cycle behind the grant
    logic        instr_rvalid_q;
    logic        instr_ram_q;
    logic        data_rvalid_q;
    logic        data_ram_q;
    logic [31:0] periph_rdata_q;

    function automatic reg_req_t to_reg(input obi_req_t req, input logic sel);
        reg_req_t r;
        r.valid  = req.req & sel;
        r.we     = req.we;
        r.be     = req.be;
        r.offset = req.addr[5:2];
        r.wdata  = req.wdata;
        return r;
    endfunction

    // Decode on the 4 KiB page
    assign sel_ram      = data_req_i.addr[31:12] == RAM_BASE[31:12];
    assign sel_uart     = data_req_i.addr[31:12] == UART_BASE[31:12];
    assign sel_gpio     = data_req_i.addr[31:12] == GPIO_BASE[31:12];
    assign sel_timer    = data_req_i.addr[31:12] == TIMER_BASE[31:12];
    assign instr_in_ram = instr_req_i.addr[31:12] == RAM_BASE[31:12];

    always_comb begin
        ram_instr_req     = instr_req_i;
        ram_instr_req.req = instr_req_i.req & instr_in_ram;
        ram_data_req      = data_req_i;
        ram_data_req.req  = data_req_i.req & sel_ram;
    end

    assign uart_req  = to_reg(data_req_i, sel_uart);
    assign gpio_req  = to_reg(data_req_i, sel_gpio);
    assign timer_req = to_reg(data_req_i, sel_timer);

    assign periph_rdata = sel_uart  ? uart_rdata  :
                          sel_gpio  ? gpio_rdata  :
                          sel_timer ? timer_rdata : 32'd0;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            instr_rvalid_q <= 1'b0;
            instr_ram_q    <= 1'b0;
            data_rvalid_q  <= 1'b0;
            data_ram_q     <= 1'b0;
        end else begin
            instr_rvalid_q <= instr_req_i.req;
            instr_ram_q    <= instr_req_i.req & instr_in_ram;
            data_rvalid_q  <= data_req_i.req;
            data_ram_q     <= data_req_i.req & sel_ram;
        end
    end

    always_ff @(posedge clk_i) begin
        if (data_req_i.req) begin
            periph_rdata_q <= periph_rdata;
        end
    end

    // Every request is granted in the cycle it shows up
    assign instr_rsp_o.gnt    = instr_req_i.req;
    assign instr_rsp_o.rvalid = instr_rvalid_q;
    assign instr_rsp_o.rdata  = instr_ram_q ? ram_instr_rdata : 32'd0;

    assign data_rsp_o.gnt    = data_req_i.req;
    assign data_rsp_o.rvalid = data_rvalid_q;
    assign data_rsp_o.rdata  = data_ram_q ? ram_data_rdata : periph_rdata_q;

    mcu_ram u_ram (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .instr_req_i   (ram_instr_req),
        .data_req_i    (ram_data_req),
        .instr_rdata_o (ram_instr_rdata),
        .data_rdata_o  (ram_data_rdata)
    );

    mcu_uart u_uart (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .reg_i    (uart_req),
        .rdata_o  (uart_rdata),
        .rx_i     (rx_i),
        .tx_o     (tx_o)
    );

    mcu_gpio_timer u_gpio_timer (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .gpio_reg_i    (gpio_req),
        .timer_reg_i   (timer_req),
        .gpio_rdata_o  (gpio_rdata),
        .timer_rdata_o (timer_rdata),
        .in_i          (in_i),
        .out_o         (out_o),
        .irq_o         (irq_o),
        .irq_ack_i     (irq_ack_i),
        .irq_id_i      (irq_id_i)
    );

endmodule

`default_nettype wire

/* mcu_gpio_timer.sv */
`default_nettype none

module mcu_gpio_timer import mcu_pkg::*; (
    input  wire logic        clk_i,
    input  wire logic        arst_n_i,
    input  wire reg_req_t    gpio_reg_i,
    input  wire reg_req_t    timer_reg_i,
    output logic      [31:0] gpio_rdata_o,
    output logic      [31:0] timer_rdata_o,
    input  wire logic [15:0] in_i,
    output logic      [15:0] out_o,
    output logic             irq_o,
    input  wire logic        irq_ack_i,
    input  wire logic [4:0]  irq_id_i
);

    logic [31:0] out_q;
    logic [15:0] in_meta;
    logic [15:0] in_sync;

    logic [31:0] count_q;
    logic [31:0] cmp_q;
    logic [1:0]  ctrl_q;
    logic        pending_q;
    logic        timer_wr;
    logic        hit;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            out_q <= '0;
        end else if (gpio_reg_i.valid && gpio_reg_i.we && gpio_reg_i.offset == GPIO_OUT) begin
            for (int b = 0; b < 4; b++) begin
                if (gpio_reg_i.be[b]) begin
                    out_q[b*8 +: 8] <= gpio_reg_i.wdata[b*8 +: 8];
                end
            end
        end
    end

    assign out_o = out_q[15:0];

    // Pins are asynchronous to clk
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            in_meta <= '0;
            in_sync <= '0;
        end else begin
            in_meta <= in_i;
            in_sync <= in_meta;
        end
    end

    always_comb begin
        case (gpio_reg_i.offset)
            GPIO_OUT: gpio_rdata_o = out_q;
            GPIO_IN:  gpio_rdata_o = {16'd0, in_sync};
            default:  gpio_rdata_o = '0;
        endcase
    end

    // Timer registers take whole words
    assign timer_wr = timer_reg_i.valid && timer_reg_i.we && |timer_reg_i.be;
    assign hit      = ctrl_q[CTRL_ENABLE] && count_q == cmp_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            count_q <= '0;
            cmp_q   <= '0;
            ctrl_q  <= '0;
        end else begin
            if (timer_wr && timer_reg_i.offset == TIMER_COUNT) begin
                count_q <= timer_reg_i.wdata;
            end else if (hit) begin
                count_q <= '0;
            end else if (ctrl_q[CTRL_ENABLE]) begin
                count_q <= count_q + 32'd1;
            end
            if (timer_wr && timer_reg_i.offset == TIMER_CMP) begin
                cmp_q <= timer_reg_i.wdata;
            end
            if (timer_wr && timer_reg_i.offset == TIMER_CTRL) begin
                ctrl_q <= timer_reg_i.wdata[1:0];
            end
        end
    end

    // New compare event takes priority over an ack
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pending_q <= 1'b0;
        end else if (hit) begin
            pending_q <= 1'b1;
        end else if (irq_ack_i && irq_id_i == TIMER_IRQ_ID) begin
            pending_q <= 1'b0;
        end
    end

    assign irq_o = pending_q & ctrl_q[CTRL_IRQ_EN];

    always_comb begin
        case (timer_reg_i.offset)
            TIMER_COUNT: timer_rdata_o = count_q;
            TIMER_CMP:   timer_rdata_o = cmp_q;
            TIMER_CTRL:  timer_rdata_o = {30'd0, ctrl_q};
            default:     timer_rdata_o = '0;
        endcase
    end

endmodule

`default_nettype wire

/* mcu_pkg.sv */
`default_nettype none

package mcu_pkg;

    // Memory map
    localparam int          RAM_WORDS = 1024;
    localparam int          RAM_AW    = $clog2(RAM_WORDS);
    localparam logic [31:0] RAM_BASE  = 32'h0000_0000;

    localparam logic [31:0] UART_BASE  = 32'h1000_0000;
    localparam logic [31:0] GPIO_BASE  = 32'h1000_1000;
    localparam logic [31:0] TIMER_BASE = 32'h1000_2000;

    // UART register word offsets
    localparam logic [3:0] UART_DATA   = 4'd0;
    localparam logic [3:0] UART_STATUS = 4'd1;
    localparam logic [3:0] UART_DIV    = 4'd2;

    // GPIO register word offsets
    localparam logic [3:0] GPIO_OUT = 4'd0;
    localparam logic [3:0] GPIO_IN  = 4'd1;

    // Timer register word offsets
    localparam logic [3:0] TIMER_COUNT = 4'd0;
    localparam logic [3:0] TIMER_CMP   = 4'd1;
    localparam logic [3:0] TIMER_CTRL  = 4'd2;

    // Bits in UART_STATUS
    localparam int STATUS_TX_BUSY  = 0;
    localparam int STATUS_RX_VALID = 1;

    // Bits in TIMER_CTRL
    localparam int CTRL_ENABLE = 0;
    localparam int CTRL_IRQ_EN = 1;

    // Clocks per bit out of reset
    localparam logic [15:0] UART_DIV_RESET = 16'd8;

    localparam logic [4:0] TIMER_IRQ_ID = 5'd7;

    // Core side request, one per port
    typedef struct packed {
        logic        req;
        logic        we;
        logic [3:0]  be;
        logic [31:0] addr;
        logic [31:0] wdata;
    } obi_req_t;

    typedef struct packed {
        logic        gnt;
        logic        rvalid;
        logic [31:0] rdata;
    } obi_rsp_t;

    // Register access toward a peripheral, offset is a word index
    typedef struct packed {
        logic        valid;
        logic        we;
        logic [3:0]  be;
        logic [3:0]  offset;
        logic [31:0] wdata;
    } reg_req_t;

endpackage

`default_nettype wire

/* mcu_ram.sv */
`default_nettype none

module mcu_ram import mcu_pkg::*; (
    input  wire logic        clk_i,
    input  wire logic        arst_n_i,
    input  wire obi_req_t    instr_req_i,
    input  wire obi_req_t    data_req_i,
    output logic      [31:0] instr_rdata_o,
    output logic      [31:0] data_rdata_o
);

    logic [31:0] mem [RAM_WORDS];

    logic [RAM_AW-1:0] instr_idx;
    logic [RAM_AW-1:0] data_idx;

    // Word index only, byte offset and upper bits are dropped
    assign instr_idx = instr_req_i.addr[RAM_AW+1:2];
    assign data_idx  = data_req_i.addr[RAM_AW+1:2];

    // Byte-enabled writes from the data port
    always_ff @(posedge clk_i) begin
        if (data_req_i.req && data_req_i.we) begin
            for (int b = 0; b < 4; b++) begin
                if (data_req_i.be[b]) begin
                    mem[data_idx][b*8 +: 8] <= data_req_i.wdata[b*8 +: 8];
                end
            end
        end
    end

    // Both ports read one cycle after the request
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            instr_rdata_o <= '0;
            data_rdata_o  <= '0;
        end else begin
            if (instr_req_i.req) begin
                instr_rdata_o <= mem[instr_idx];
            end
            if (data_req_i.req) begin
                data_rdata_o <= mem[data_idx];
            end
        end
    end

endmodule

`default_nettype wire

/* mcu_uart.sv */
`default_nettype none

module mcu_uart import mcu_pkg::*; (
    input  wire logic        clk_i,
    input  wire logic        arst_n_i,
    input  wire reg_req_t    reg_i,
    output logic      [31:0] rdata_o,
    input  wire logic        rx_i,
    output logic             tx_o
);

    logic [15:0] div_q;

    // Transmitter
    logic        tx_busy;
    logic [9:0]  tx_shift;
    logic [3:0]  tx_bit;
    logic [15:0] tx_cnt;

    // Receiver
    logic        rx_meta;
    logic        rx_sync;
    logic        rx_active;
    logic [3:0]  rx_bit;
    logic [15:0] rx_cnt;
    logic [15:0] rx_target;
    logic [7:0]  rx_shift;
    logic [7:0]  rx_data;
    logic        rx_valid;
    logic        rx_done;

    logic wr_data;
    logic wr_div;
    logic rd_data;

    assign wr_data = reg_i.valid && reg_i.we && reg_i.offset == UART_DATA && reg_i.be[0];
    assign wr_div  = reg_i.valid && reg_i.we && reg_i.offset == UART_DIV;
    assign rd_data = reg_i.valid && !reg_i.we && reg_i.offset == UART_DATA;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            div_q <= UART_DIV_RESET;
        end else if (wr_div) begin
            if (reg_i.be[0]) div_q[7:0]  <= reg_i.wdata[7:0];
            if (reg_i.be[1]) div_q[15:8] <= reg_i.wdata[15:8];
        end
    end

    // Frame is {stop, data, start}, shifted out LSB first
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            tx_busy  <= 1'b0;
            tx_shift <= '1;
            tx_bit   <= '0;
            tx_cnt   <= '0;
        end else if (!tx_busy) begin
            if (wr_data) begin
                tx_shift <= {1'b1, reg_i.wdata[7:0], 1'b0};
                tx_busy  <= 1'b1;
                tx_bit   <= '0;
                tx_cnt   <= '0;
            end
        end else if (tx_cnt == div_q - 16'd1) begin
            tx_cnt   <= '0;
            tx_shift <= {1'b1, tx_shift[9:1]};
            if (tx_bit == 4'd9) begin
                tx_busy <= 1'b0;
            end else begin
                tx_bit <= tx_bit + 4'd1;
            end
        end else begin
            tx_cnt <= tx_cnt + 16'd1;
        end
    end

    // Idles high, since the shifter fills with ones
    assign tx_o = tx_shift[0];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx_i;
            rx_sync <= rx_meta;
        end
    end

    // Half a bit to reach the middle of start, then whole bits
    assign rx_target = (rx_bit == 4'd0) ? {1'b0, div_q[15:1]} : div_q - 16'd1;
    assign rx_done   = rx_active && rx_cnt == rx_target && rx_bit == 4'd9 && rx_sync;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rx_active <= 1'b0;
            rx_bit    <= '0;
            rx_cnt    <= '0;
        end else if (!rx_active) begin
            if (!rx_sync) begin
                rx_active <= 1'b1;
                rx_bit    <= '0;
                rx_cnt    <= '0;
            end
        end else if (rx_cnt == rx_target) begin
            rx_cnt <= '0;
            rx_bit <= rx_bit + 4'd1;
            // A glitch on the line is not a start bit
            if ((rx_bit == 4'd0 && rx_sync) || rx_bit == 4'd9) begin
                rx_active <= 1'b0;
            end
        end else begin
            rx_cnt <= rx_cnt + 16'd1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rx_active && rx_cnt == rx_target && rx_bit != 4'd0 && rx_bit != 4'd9) begin
            rx_shift <= {rx_sync, rx_shift[7:1]};
        end
        if (rx_done) begin
            rx_data <= rx_shift;
        end
    end

    // A fresh byte wins over a read in the same cycle
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rx_valid <= 1'b0;
        end else if (rx_done) begin
            rx_valid <= 1'b1;
        end else if (rd_data) begin
            rx_valid <= 1'b0;
        end
    end

    always_comb begin
        rdata_o = '0;
        case (reg_i.offset)
            UART_DATA: rdata_o = {24'd0, rx_data};
            UART_STATUS: begin
                rdata_o[STATUS_TX_BUSY]  = tx_busy;
                rdata_o[STATUS_RX_VALID] = rx_valid;
            end
            UART_DIV: rdata_o = {16'd0, div_q};
            default: rdata_o = '0;
        endcase
    end

endmodule

`default_nettype wire

/* project.f */
mcu_pkg.sv
mcu_ram.sv
mcu_uart.sv
mcu_gpio_timer.sv
mcu_bus.sv
mcu.sv
tb_clock.sv
tb_mcu.sv

/* tb_clock.sv */
`default_nettype none

module tb_clock (
    output logic clk_o
);

    timeunit 1ns;
    timeprecision 1ps;

    // 40 ns period, starts low
    initial begin
        clk_o = 1'b0;
        forever begin
            #20;
            clk_o = ~clk_o;
        end
    end

endmodule

`default_nettype wire

/* tb_mcu.sv */
`default_nettype none

module tb_mcu import mcu_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int WAIT_LIMIT = 200;
    localparam int POLL_LIMIT = 100;

    logic        clk;
    logic        arst_n;
    obi_req_t    instr_req;
    obi_rsp_t    instr_rsp;
    obi_req_t    data_req;
    obi_rsp_t    data_rsp;
    logic        uart_line;
    logic [15:0] gpio_in;
    logic [15:0] gpio_out;
    logic        irq;
    logic        irq_ack;
    logic [4:0]  irq_id;

    // Shadow of RAM contents and the words written so far
    logic [31:0] shadow [RAM_WORDS];
    int          written[$];
    int          cycle_count = 0;
    logic        instr_gnt_q = 1'b0;
    logic        data_gnt_q  = 1'b0;

    tb_clock clock0 (
        .clk_o (clk)
    );

    // UART tx is looped back into rx
    mcu dut0 (
        .clk_i       (clk),
        .arst_n_i    (arst_n),
        .instr_req_i (instr_req),
        .instr_rsp_o (instr_rsp),
        .data_req_i  (data_req),
        .data_rsp_o  (data_rsp),
        .rx_i        (uart_line),
        .tx_o        (uart_line),
        .in_i        (gpio_in),
        .out_o       (gpio_out),
        .irq_o       (irq),
        .irq_ack_i   (irq_ack),
        .irq_id_i    (irq_id)
    );

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            stop_run($sformatf("Mismatch at %0d ns: %s got %h expected %h",
                               $time, name, got, exp));
        end
    endtask

    // Bytes with their enable set take the new value
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0] be);
        logic [31:0] word;
        word = old_word;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                word[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return word;
    endfunction

    function automatic logic [31:0] reg_addr(input logic [31:0] base, input logic [3:0] offset);
        return base | {26'd0, offset, 2'b00};
    endfunction

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // rvalid must follow every granted cycle by exactly one cycle
    always @(negedge clk) begin
        if (arst_n === 1'b1) begin
            check_value("instr_rsp.rvalid", 32'(instr_rsp.rvalid), 32'(instr_gnt_q));
            check_value("data_rsp.rvalid", 32'(data_rsp.rvalid), 32'(data_gnt_q));
        end
        instr_gnt_q = instr_rsp.gnt;
        data_gnt_q  = data_rsp.gnt;
    end

    // One data port access held until granted
    task automatic data_access(input logic we, input logic [31:0] addr,
                               input logic [31:0] wdata, input logic [3:0] be,
                               output logic [31:0] rdata);
        int n;
        @(posedge clk);
        #5;
        data_req.req   = 1'b1;
        data_req.we    = we;
        data_req.be    = be;
        data_req.addr  = addr;
        data_req.wdata = wdata;
        n = 0;
        @(negedge clk);
        while (!data_rsp.gnt) begin
            assert (n < WAIT_LIMIT) else stop_run("Data port request was never granted");
            @(negedge clk);
            n++;
        end
        @(posedge clk);
        #5;
        data_req = '0;
        n = 0;
        @(negedge clk);
        while (!data_rsp.rvalid) begin
            assert (n < WAIT_LIMIT) else stop_run("Data port response never arrived");
            @(negedge clk);
            n++;
        end
        rdata = data_rsp.rdata;
    endtask

    task automatic data_write(input logic [31:0] addr, input logic [31:0] wdata,
                              input logic [3:0] be);
        logic [31:0] unused;
        data_access(1'b1, addr, wdata, be, unused);
    endtask

    task automatic data_read(input logic [31:0] addr, output logic [31:0] rdata);
        data_access(1'b0, addr, 32'd0, 4'hF, rdata);
    endtask

    task automatic read_expect(input string name, input logic [31:0] addr,
                               input logic [31:0] exp);
        logic [31:0] rdata;
        data_read(addr, rdata);
        check_value(name, rdata, exp);
    endtask

    // Back-to-back RAM reads on one port with responses matched in order
    task automatic ram_read_burst(input logic use_instr, input int count);
        logic [31:0] expect_q[$];
        obi_req_t    r;
        obi_rsp_t    s;
        int          idx;
        int          issued;
        int          n;
        string       name;
        r      = '0;
        s      = '0;
        idx    = 0;
        issued = 0;
        n      = 0;
        name   = use_instr ? "instr_rsp.rdata" : "data_rsp.rdata";
        while (issued < count || expect_q.size() > 0) begin
            assert (n < WAIT_LIMIT) else stop_run("RAM read burst did not complete in time");
            @(posedge clk);
            #5;
            if (!r.req || s.gnt) begin
                r = '0;
                if (issued < count) begin
                    idx    = written[$urandom % written.size()];
                    r.req  = 1'b1;
                    r.be   = 4'hF;
                    r.addr = RAM_BASE + (32'(idx) << 2);
                end
            end
            if (use_instr) begin
                instr_req = r;
            end else begin
                data_req = r;
            end
            @(negedge clk);
            s = use_instr ? instr_rsp : data_rsp;
            if (s.rvalid) begin
                assert (expect_q.size() > 0) else stop_run("rvalid seen with no read pending");
                check_value(name, s.rdata, expect_q.pop_front());
            end
            if (r.req && s.gnt) begin
                expect_q.push_back(shadow[idx]);
                issued++;
            end
            n++;
        end
    endtask

    task automatic reset_check();
        check_value("instr_rsp.gnt", 32'(instr_rsp.gnt), 32'd0);
        check_value("instr_rsp.rvalid", 32'(instr_rsp.rvalid), 32'd0);
        check_value("data_rsp.gnt", 32'(data_rsp.gnt), 32'd0);
        check_value("data_rsp.rvalid", 32'(data_rsp.rvalid), 32'd0);
        check_value("out_o", 32'(gpio_out), 32'd0);
        check_value("irq_o", 32'(irq), 32'd0);
        check_value("tx_o", 32'(uart_line), 32'd1);
        read_expect("UART_DIV", reg_addr(UART_BASE, UART_DIV), 32'(UART_DIV_RESET));
        read_expect("TIMER_CTRL", reg_addr(TIMER_BASE, TIMER_CTRL), 32'd0);
        read_expect("unmapped rdata", 32'h2000_0000, 32'd0);
    endtask

    task automatic ram_test();
        int          idx;
        logic [31:0] wdata;
        logic [3:0]  be;
        // Whole words first so no byte stays unknown
        for (int i = 0; i < 16; i++) begin
            idx   = $urandom % RAM_WORDS;
            wdata = $urandom;
            data_write(RAM_BASE + (32'(idx) << 2), wdata, 4'hF);
            shadow[idx] = wdata;
            written.push_back(idx);
        end
        for (int i = 0; i < 32; i++) begin
            idx   = written[$urandom % written.size()];
            wdata = $urandom;
            be    = 4'($urandom);
            data_write(RAM_BASE + (32'(idx) << 2), wdata, be);
            shadow[idx] = merge_bytes(shadow[idx], wdata, be);
        end
        ram_read_burst(1'b0, 24);
        ram_read_burst(1'b1, 24);
    endtask

    task automatic gpio_test();
        logic [31:0] model;
        logic [31:0] wdata;
        logic [3:0]  be;
        logic [15:0] pins;
        model = '0;
        for (int i = 0; i < 8; i++) begin
            wdata = $urandom;
            be    = 4'($urandom);
            data_write(reg_addr(GPIO_BASE, GPIO_OUT), wdata, be);
            model = merge_bytes(model, wdata, be);
            check_value("out_o", 32'(gpio_out), 32'(model[15:0]));
            read_expect("GPIO_OUT", reg_addr(GPIO_BASE, GPIO_OUT), model);
        end
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            #5;
            pins    = 16'($urandom);
            gpio_in = pins;
            // Two synchronizer flops before the value is readable
            repeat (3) @(posedge clk);
            read_expect("GPIO_IN", reg_addr(GPIO_BASE, GPIO_IN), {16'd0, pins});
        end
    endtask

    task automatic uart_test();
        logic [15:0] div;
        logic [7:0]  sent;
        logic [31:0] st;
        int          polls;
        div = 16'(4 + $urandom % 5);
        data_write(reg_addr(UART_BASE, UART_DIV), {16'd0, div}, 4'b0011);
        read_expect("UART_DIV", reg_addr(UART_BASE, UART_DIV), {16'd0, div});
        for (int i = 0; i < 4; i++) begin
            sent = 8'($urandom);
            data_write(reg_addr(UART_BASE, UART_DATA), {24'd0, sent}, 4'b0001);
            data_read(reg_addr(UART_BASE, UART_STATUS), st);
            check_value("UART_STATUS tx_busy", 32'(st[STATUS_TX_BUSY]), 32'd1);
            // Frame in flight so this byte must be dropped
            data_write(reg_addr(UART_BASE, UART_DATA), {24'd0, ~sent}, 4'b0001);
            polls = 0;
            data_read(reg_addr(UART_BASE, UART_STATUS), st);
            while (!st[STATUS_RX_VALID] || st[STATUS_TX_BUSY]) begin
                assert (polls < POLL_LIMIT) else stop_run("UART loopback byte never arrived");
                data_read(reg_addr(UART_BASE, UART_STATUS), st);
                polls++;
            end
            // Line idles high between frames
            for (int c = 0; c < 2 * div; c++) begin
                @(negedge clk);
                check_value("tx_o", 32'(uart_line), 32'd1);
            end
            read_expect("UART_DATA", reg_addr(UART_BASE, UART_DATA), {24'd0, sent});
            data_read(reg_addr(UART_BASE, UART_STATUS), st);
            check_value("UART_STATUS rx_valid", 32'(st[STATUS_RX_VALID]), 32'd0);
        end
    endtask

    task automatic wait_irq_high(output int at);
        int n;
        n = 0;
        @(negedge clk);
        while (!irq) begin
            assert (n < WAIT_LIMIT) else stop_run("Timer interrupt did not rise in time");
            @(negedge clk);
            n++;
        end
        at = cycle_count;
    endtask

    // One-cycle acknowledge that returns at the negedge after it took effect
    task automatic ack_irq(input logic [4:0] id);
        @(posedge clk);
        #5;
        irq_ack = 1'b1;
        irq_id  = id;
        @(posedge clk);
        #5;
        irq_ack = 1'b0;
        irq_id  = '0;
        @(negedge clk);
    endtask

    task automatic timer_test();
        logic [31:0] cmp;
        int          t_prev;
        int          t_now;
        cmp = 32'(3 + $urandom % 6);
        data_write(reg_addr(TIMER_BASE, TIMER_CMP), cmp, 4'hF);
        data_write(reg_addr(TIMER_BASE, TIMER_CTRL),
                   (32'd1 << CTRL_ENABLE) | (32'd1 << CTRL_IRQ_EN), 4'hF);
        wait_irq_high(t_prev);
        for (int i = 0; i < 4; i++) begin
            ack_irq(TIMER_IRQ_ID);
            check_value("irq_o", 32'(irq), 32'd0);
            wait_irq_high(t_now);
            check_value("irq_o spacing", 32'(t_now - t_prev), cmp + 32'd1);
            t_prev = t_now;
        end
        ack_irq(5'd3);
        check_value("irq_o", 32'(irq), 32'd1);
        // Pending stays set but the line is masked
        data_write(reg_addr(TIMER_BASE, TIMER_CTRL), 32'd1 << CTRL_ENABLE, 4'hF);
        repeat (2 * (cmp + 1)) begin
            @(negedge clk);
            check_value("irq_o", 32'(irq), 32'd0);
        end
    endtask

    initial begin
        void'($urandom(32'h4469));
        arst_n    = 1'b0;
        instr_req = '0;
        data_req  = '0;
        gpio_in   = '0;
        irq_ack   = 1'b0;
        irq_id    = '0;
        repeat (16) @(posedge clk);
        #5;
        arst_n = 1'b1;
        @(negedge clk);
        reset_check();
        ram_test();
        gpio_test();
        uart_test();
        timer_test();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire
